// ==== verilog/vec_runtime_pkg.sv ====
/*
 * Vector runtime harness shared definitions
 * APB request and response structs, the dispatch payload and the register map
 */

package vec_runtime_pkg;

  // APB request from the bus master
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response from the slave
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Dispatch payload, cost of the instruction in accelerator cycles
  typedef struct packed {
    logic [7:0] busy_cycles;
  } acc_req_t;

  // Control register offsets
  localparam logic [31:0] RegExitOff      = 32'h0000_0000;
  localparam logic [31:0] RegCntEnOff     = 32'h0000_0008;
  localparam logic [31:0] RegRuntimeLoOff = 32'h0000_0010;
  localparam logic [31:0] RegRuntimeHiOff = 32'h0000_0014;

  // UART window, selected by address bit 8
  localparam logic [31:0] UartBase    = 32'h0000_0100;
  localparam logic [31:0] UartThrOff  = 32'h0000_0000;
  localparam logic [31:0] UartLsrOff  = 32'h0000_0014;
  // Transmitter holding register and shift register empty
  localparam logic [31:0] UartLsrIdle = 32'h0000_0060;

endpackage : vec_runtime_pkg

// ==== verilog/acc_busy_model.sv ====
/*
 * Accelerator busy model
 * Stands in for the vector unit by adding each request's cost to a
 * remaining-work count that drains by one per cycle
 */

`timescale 1ns/1ps

module acc_busy_model (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      acc_req_valid_i,
  input  vec_runtime_pkg::acc_req_t acc_req_i,
  output logic                      acc_idle_o
);

  // Enough headroom for a long run of maximum-cost requests
  localparam int unsigned WorkWidth = 16;

  logic [WorkWidth-1:0] work_d;
  logic [WorkWidth-1:0] work_q;

  always_comb begin
    // Hold by default
    work_d = work_q;
    if (acc_req_valid_i) begin
      // New request extends the busy window by its cost
      work_d = work_q + WorkWidth'(acc_req_i.busy_cycles);
    end else if (work_q != '0) begin
      // One cycle of work retired
      work_d = work_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      work_q <= '0;
    end else begin
      work_q <= work_d;
    end
  end

  // Idle only when nothing is left to retire
  // A zero-cost request never leaves idle
  assign acc_idle_o = (work_q == '0);

endmodule : acc_busy_model

// ==== verilog/runtime_counter.sv ====
/*
 * Runtime counter
 * Counts from the first dispatch under a software enable and latches the
 * count into a readable buffer each time the accelerator drains
 */

`timescale 1ns/1ps

module runtime_counter #(
  parameter int unsigned CntWidth = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                acc_req_valid_i,
  input  logic                acc_idle_i,
  input  logic                cnt_en_i,
  output logic [CntWidth-1:0] runtime_o
);

  logic                cnt_en_d;
  logic                cnt_en_q;
  logic [CntWidth-1:0] cnt_d;
  logic [CntWidth-1:0] cnt_q;
  logic                upd_d;
  logic                upd_q;
  logic [CntWidth-1:0] buf_d;
  logic [CntWidth-1:0] buf_q;

  // Enable tracking
  always_comb begin
    if (!cnt_en_q) begin
      // Start on the first dispatch seen while software allows it
      cnt_en_d = acc_req_valid_i & cnt_en_i;
    end else begin
      // Software clear only stops us once the accelerator has drained
      cnt_en_d = cnt_en_i | ~acc_idle_i;
    end
  end

  // Free-running count while enabled
  always_comb begin
    cnt_d = cnt_q;
    if (cnt_en_q) begin
      cnt_d = cnt_q + 1'b1;
    end
  end

  // Update flag and runtime buffer
  always_comb begin
    upd_d = upd_q;
    buf_d = buf_q;
    if (acc_req_valid_i) begin
      // Any dispatch arms a later update
      upd_d = 1'b1;
    end else if (upd_q && acc_idle_i) begin
      // Drained with nothing new in flight, so capture the count
      buf_d = cnt_q;
      upd_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_en_q <= 1'b0;
      cnt_q    <= '0;
      upd_q    <= 1'b0;
      buf_q    <= '0;
    end else begin
      cnt_en_q <= cnt_en_d;
      cnt_q    <= cnt_d;
      upd_q    <= upd_d;
      buf_q    <= buf_d;
    end
  end

  // Software sees only the latched value
  assign runtime_o = buf_q;

endmodule : runtime_counter

// ==== verilog/mock_uart.sv ====
/*
 * Mock UART
 * APB slave that turns THR writes into single-cycle character strobes and
 * reports an always-empty transmitter on LSR reads
 */

`timescale 1ns/1ps

module mock_uart (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vec_runtime_pkg::apb_req_t apb_req_i,
  output vec_runtime_pkg::apb_rsp_t apb_rsp_o,
  output logic                      char_valid_o,
  output logic [7:0]                char_o
);

  import vec_runtime_pkg::*;

  logic        access;
  logic [31:0] offset;
  logic        thr_wr;
  logic        lsr_rd;
  logic        char_valid_q;
  logic [7:0]  char_q;

  // Access phase of a transfer
  assign access = apb_req_i.psel & apb_req_i.penable;

  // Offset within the window
  assign offset = apb_req_i.paddr & ~UartBase;

  assign thr_wr = access & apb_req_i.pwrite & (offset == UartThrOff);
  assign lsr_rd = access & ~apb_req_i.pwrite & (offset == UartLsrOff);

  // Strobe lasts exactly one cycle after the access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      char_valid_q <= 1'b0;
    end else begin
      char_valid_q <= thr_wr;
    end
  end

  // Character byte, only meaningful with the strobe
  always_ff @(posedge clk_i) begin
    if (thr_wr) begin
      char_q <= apb_req_i.pwdata[7:0];
    end
  end

  // Zero wait states, never an error
  always_comb begin
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    apb_rsp_o.prdata  = '0;
    if (lsr_rd) begin
      apb_rsp_o.prdata = UartLsrIdle;
    end
  end

  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;

endmodule : mock_uart

// ==== verilog/ctrl_regs.sv ====
/*
 * Control register block
 * APB slave holding the exit code and the counter enable, showing the latched
 * runtime and forwarding the UART window unchanged
 */

`timescale 1ns/1ps

module ctrl_regs #(
  parameter int unsigned CntWidth = 64
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vec_runtime_pkg::apb_req_t apb_req_i,
  output vec_runtime_pkg::apb_rsp_t apb_rsp_o,
  output vec_runtime_pkg::apb_req_t uart_req_o,
  input  vec_runtime_pkg::apb_rsp_t uart_rsp_i,
  input  logic [CntWidth-1:0]       runtime_i,
  output logic                      cnt_en_o,
  output logic [31:0]               exit_o
);

  import vec_runtime_pkg::*;

  logic        uart_sel;
  logic        access;
  logic        wr_en;
  logic        exit_hit;
  logic        cnt_en_hit;
  logic        rt_lo_hit;
  logic        rt_hi_hit;
  logic [63:0] runtime_ext;
  logic [31:0] exit_d;
  logic [31:0] exit_q;
  logic        cnt_en_d;
  logic        cnt_en_q;

  // Address bit 8 selects the UART window
  assign uart_sel = (apb_req_i.paddr & UartBase) != '0;

  // Access phase of a local transfer
  assign access = apb_req_i.psel & apb_req_i.penable & ~uart_sel;
  assign wr_en  = access & apb_req_i.pwrite;

  // Local decode
  assign exit_hit   = (apb_req_i.paddr == RegExitOff);
  assign cnt_en_hit = (apb_req_i.paddr == RegCntEnOff);
  assign rt_lo_hit  = (apb_req_i.paddr == RegRuntimeLoOff);
  assign rt_hi_hit  = (apb_req_i.paddr == RegRuntimeHiOff);

  // High word is zero-extended for counters narrower than 64 bits
  assign runtime_ext = 64'(runtime_i);

  // Forward the bus with select gated by the window decode
  always_comb begin
    uart_req_o      = apb_req_i;
    uart_req_o.psel = apb_req_i.psel & uart_sel;
  end

  // Writable registers
  always_comb begin
    exit_d   = exit_q;
    cnt_en_d = cnt_en_q;
    if (wr_en && exit_hit) begin
      exit_d = apb_req_i.pwdata;
    end
    if (wr_en && cnt_en_hit) begin
      // Only bit 0 is implemented
      cnt_en_d = apb_req_i.pwdata[0];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      exit_q   <= '0;
      cnt_en_q <= 1'b0;
    end else begin
      exit_q   <= exit_d;
      cnt_en_q <= cnt_en_d;
    end
  end

  // Read mux and error response
  always_comb begin
    apb_rsp_o.prdata  = '0;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = 1'b0;
    if (uart_sel) begin
      // UART answers on its own
      apb_rsp_o = uart_rsp_i;
    end else if (access) begin
      if (exit_hit) begin
        apb_rsp_o.prdata = exit_q;
      end else if (cnt_en_hit) begin
        apb_rsp_o.prdata = {31'h0, cnt_en_q};
      end else if (rt_lo_hit) begin
        apb_rsp_o.prdata  = runtime_ext[31:0];
        // Runtime words are read-only
        apb_rsp_o.pslverr = apb_req_i.pwrite;
      end else if (rt_hi_hit) begin
        apb_rsp_o.prdata  = runtime_ext[63:32];
        apb_rsp_o.pslverr = apb_req_i.pwrite;
      end else begin
        // Unmapped offset
        apb_rsp_o.pslverr = 1'b1;
      end
    end
  end

  assign exit_o   = exit_q;
  assign cnt_en_o = cnt_en_q;

endmodule : ctrl_regs

// ==== verilog/vec_runtime_harness.sv ====
/*
 * Vector runtime harness top level
 * Connects the APB register block, the mock UART, the accelerator busy model
 * and the runtime counter
 */

`timescale 1ns/1ps

module vec_runtime_harness #(
  parameter int unsigned CntWidth = 64
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  vec_runtime_pkg::apb_req_t apb_req_i,
  output vec_runtime_pkg::apb_rsp_t apb_rsp_o,
  input  logic                      acc_req_valid_i,
  input  vec_runtime_pkg::acc_req_t acc_req_i,
  output logic                      acc_idle_o,
  output logic [31:0]               exit_o,
  output logic                      char_valid_o,
  output logic [7:0]                char_o
);

  import vec_runtime_pkg::*;

  // Register block to UART
  apb_req_t            uart_req;
  apb_rsp_t            uart_rsp;
  // Accelerator state and counter control
  logic                acc_idle;
  logic                cnt_en;
  logic [CntWidth-1:0] runtime_buf;

  ctrl_regs #(
    .CntWidth(CntWidth)
  ) i_ctrl_regs (
    .clk_i     (clk_i      ),
    .rst_ni    (rst_ni     ),
    .apb_req_i (apb_req_i  ),
    .apb_rsp_o (apb_rsp_o  ),
    .uart_req_o(uart_req   ),
    .uart_rsp_i(uart_rsp   ),
    .runtime_i (runtime_buf),
    .cnt_en_o  (cnt_en     ),
    .exit_o    (exit_o     )
  );

  mock_uart i_mock_uart (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .apb_req_i   (uart_req    ),
    .apb_rsp_o   (uart_rsp    ),
    .char_valid_o(char_valid_o),
    .char_o      (char_o      )
  );

  // Dispatch strobe fans out to the model and the counter
  acc_busy_model i_acc_busy_model (
    .clk_i          (clk_i          ),
    .rst_ni         (rst_ni         ),
    .acc_req_valid_i(acc_req_valid_i),
    .acc_req_i      (acc_req_i      ),
    .acc_idle_o     (acc_idle       )
  );

  runtime_counter #(
    .CntWidth(CntWidth)
  ) i_runtime_counter (
    .clk_i          (clk_i          ),
    .rst_ni         (rst_ni         ),
    .acc_req_valid_i(acc_req_valid_i),
    .acc_idle_i     (acc_idle       ),
    .cnt_en_i       (cnt_en         ),
    .runtime_o      (runtime_buf    )
  );

  assign acc_idle_o = acc_idle;

endmodule : vec_runtime_harness

// ==== verif/tb_vec_runtime.sv ====
/*
 * Vector runtime harness testbench
 * Drives APB and dispatch strobes, tracks a cycle-level reference model and
 * checks idle, registers, UART strobes and the latched runtime
 */

`timescale 1ns/1ps

module tb_vec_runtime;

  import vec_runtime_pkg::*;

  localparam int unsigned CntWidth    = 64;
  localparam int unsigned ApbTimeout  = 16;
  localparam int unsigned IdleTimeout = 5000;
  localparam int unsigned RunLimit    = 200000;

  logic        clk_i;
  logic        rst_ni;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        acc_valid;
  acc_req_t    acc_req;
  logic        acc_idle;
  logic [31:0] exit_code;
  logic        char_valid;
  logic [7:0]  char_byte;
  integer      seed;
  int unsigned char_count;

  // Reference state, driven from DUT inputs only
  logic [31:0] ref_work;
  logic        ref_en;
  logic [63:0] ref_cnt;
  logic        ref_upd;
  logic [63:0] ref_buf;
  logic        ref_cnt_en;
  logic [31:0] ref_exit;
  logic        ref_char_valid;
  logic [7:0]  ref_char;
  logic        bus_access;
  logic        uart_hit;
  logic        thr_write;

  vec_runtime_harness #(
    .CntWidth(CntWidth)
  ) i_dut (
    .clk_i          (clk_i     ),
    .rst_ni         (rst_ni    ),
    .apb_req_i      (apb_req   ),
    .apb_rsp_o      (apb_rsp   ),
    .acc_req_valid_i(acc_valid ),
    .acc_req_i      (acc_req   ),
    .acc_idle_o     (acc_idle  ),
    .exit_o         (exit_code ),
    .char_valid_o   (char_valid),
    .char_o         (char_byte )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out waiting: %s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // Access phase decode, bit 8 selects the UART window
  assign bus_access = apb_req.psel & apb_req.penable;
  assign uart_hit   = apb_req.paddr[8];
  assign thr_write  = bus_access & apb_req.pwrite & uart_hit &
                      ((apb_req.paddr & ~UartBase) == UartThrOff);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ref_work       <= '0;
      ref_en         <= 1'b0;
      ref_cnt        <= '0;
      ref_upd        <= 1'b0;
      ref_buf        <= '0;
      ref_cnt_en     <= 1'b0;
      ref_exit       <= '0;
      ref_char_valid <= 1'b0;
      ref_char       <= '0;
    end else begin
      // Remaining work grows by the cost on a strobe, else drains by one
      if (acc_valid) begin
        ref_work <= ref_work + 32'(acc_req.busy_cycles);
      end else if (ref_work != '0) begin
        ref_work <= ref_work - 32'd1;
      end
      // Counter enable, held on until the accelerator drains
      if (!ref_en) begin
        ref_en <= acc_valid & ref_cnt_en;
      end else begin
        ref_en <= ref_cnt_en | (ref_work != '0);
      end
      if (ref_en) begin
        ref_cnt <= ref_cnt + 64'd1;
      end
      if (acc_valid) begin
        ref_upd <= 1'b1;
      end else if (ref_upd && ref_work == '0) begin
        ref_buf <= ref_cnt;
        ref_upd <= 1'b0;
      end
      // Register writes land at the end of the access cycle
      if (bus_access && apb_req.pwrite && !uart_hit) begin
        if (apb_req.paddr == RegExitOff) begin
          ref_exit <= apb_req.pwdata;
        end
        if (apb_req.paddr == RegCntEnOff) begin
          ref_cnt_en <= apb_req.pwdata[0];
        end
      end
      ref_char_valid <= thr_write;
      if (thr_write) begin
        ref_char <= apb_req.pwdata[7:0];
      end
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      char_count <= 0;
    end else if (char_valid) begin
      char_count <= char_count + 1;
    end
  end

  idle_tracks_model: assert property (@(posedge clk_i) disable iff (!rst_ni)
    acc_idle == (ref_work == '0))
    else report_mismatch("acc_idle_o differs from the remaining-work model");

  exit_tracks_model: assert property (@(posedge clk_i) disable iff (!rst_ni)
    exit_code == ref_exit)
    else report_mismatch("exit_o differs from the last exit write");

  char_strobe_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    char_valid == ref_char_valid)
    else report_mismatch("char_valid_o pulse at the wrong cycle");

  char_byte_ok: assert property (@(posedge clk_i) disable iff (!rst_ni)
    char_valid |-> (char_byte == ref_char))
    else report_mismatch("char_o differs from the written byte");

  // Setup then access, response sampled 1 ns into the access cycle
  task automatic apb_transfer(input logic write, input logic [31:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
    int unsigned waited;
    int unsigned xfer_cycles;
    @(negedge clk_i);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = write ? wdata : 32'h0;
    @(negedge clk_i);
    apb_req.penable = 1'b1;
    #1;
    waited = 0;
    while (apb_rsp.pready !== 1'b1) begin
      if (waited >= ApbTimeout) begin
        abort_on_timeout("pready on an APB transfer");
      end
      @(negedge clk_i);
      #1;
      waited++;
    end
    rdata       = apb_rsp.prdata;
    err         = apb_rsp.pslverr;
    xfer_cycles = waited + 2;
    assert (xfer_cycles == 2)
      else report_mismatch($sformatf("APB transfer took %0d cycles", xfer_cycles));
    // Transfer ends at this edge, bus returns to idle
    @(posedge clk_i);
    @(negedge clk_i);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic expect_access(input logic write, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [31:0] exp_rdata,
                               input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_transfer(write, addr, wdata, rdata, err);
    assert (err == exp_err)
      else report_mismatch($sformatf("pslverr %0b at 0x%08h, expected %0b",
                                     err, addr, exp_err));
    assert (write || err || rdata == exp_rdata)
      else report_mismatch($sformatf("read 0x%08h at 0x%08h, expected 0x%08h",
                                     rdata, addr, exp_rdata));
  endtask

  // Both runtime words must match the reference buffer
  task automatic read_runtime(output logic [63:0] value);
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err;
    apb_transfer(1'b0, RegRuntimeLoOff, 32'h0, lo, err);
    assert (!err) else report_mismatch("pslverr on runtime low read");
    apb_transfer(1'b0, RegRuntimeHiOff, 32'h0, hi, err);
    assert (!err) else report_mismatch("pslverr on runtime high read");
    value = {hi, lo};
    assert (value == ref_buf)
      else report_mismatch($sformatf("runtime 0x%016h, expected 0x%016h", value, ref_buf));
  endtask

  // Strobes with random costs up to 31 and gaps of 0 to 3 cycles
  task automatic drive_burst(input int unsigned count);
    logic [31:0] rnd;
    int unsigned gap;
    for (int unsigned i = 0; i < count; i++) begin
      @(negedge clk_i);
      rnd                 = $random(seed);
      acc_valid           = 1'b1;
      acc_req.busy_cycles = {3'b000, rnd[4:0]};
      gap                 = int'(rnd[9:8]);
      if (gap != 0) begin
        @(negedge clk_i);
        acc_valid = 1'b0;
        repeat (gap - 1) @(negedge clk_i);
      end
    end
    @(negedge clk_i);
    acc_valid = 1'b0;
  endtask

  task automatic wait_for_idle();
    int unsigned waited;
    waited = 0;
    while (acc_idle !== 1'b1) begin
      if (waited >= IdleTimeout) begin
        abort_on_timeout("accelerator idle after a burst");
      end
      @(negedge clk_i);
      waited++;
    end
  endtask

  initial begin
    int unsigned cycles;
    cycles = 0;
    while (cycles < RunLimit) begin
      @(posedge clk_i);
      cycles++;
    end
    abort_on_timeout("end of the test sequence within the cycle limit");
  end

  initial begin
    logic [63:0] runtime;
    logic [63:0] prev_runtime;
    logic [31:0] value;
    int unsigned writes;
    seed      = 32'ha773;
    rst_ni    = 1'b0;
    apb_req   = '0;
    acc_valid = 1'b0;
    acc_req   = '0;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset state
    assert (exit_code == 32'h0) else report_mismatch("exit_o not zero after reset");
    assert (!char_valid) else report_mismatch("char_valid_o high after reset");
    assert (acc_idle) else report_mismatch("acc_idle_o low after reset");
    read_runtime(runtime);
    assert (runtime == 64'h0) else report_mismatch("runtime not zero after reset");

    // Exit and enable registers, error responses
    value = $random(seed);
    expect_access(1'b1, RegExitOff, value, 32'h0, 1'b0);
    expect_access(1'b0, RegExitOff, 32'h0, value, 1'b0);
    expect_access(1'b1, RegCntEnOff, 32'hffff_fffe, 32'h0, 1'b0);
    expect_access(1'b0, RegCntEnOff, 32'h0, 32'h0, 1'b0);
    expect_access(1'b1, RegCntEnOff, 32'h0000_0003, 32'h0, 1'b0);
    expect_access(1'b0, RegCntEnOff, 32'h0, 32'h1, 1'b0);
    expect_access(1'b1, RegCntEnOff, 32'h0, 32'h0, 1'b0);
    expect_access(1'b0, 32'h0000_0004, 32'h0, 32'h0, 1'b1);
    expect_access(1'b1, 32'h0000_000c, 32'h5a, 32'h0, 1'b1);
    expect_access(1'b0, 32'h0000_0200, 32'h0, 32'h0, 1'b1);
    expect_access(1'b1, RegRuntimeLoOff, 32'h1, 32'h0, 1'b1);
    expect_access(1'b1, RegRuntimeHiOff, 32'h1, 32'h0, 1'b1);

    // UART characters and status
    writes = 6;
    for (int unsigned i = 0; i < writes; i++) begin
      value = $random(seed);
      expect_access(1'b1, UartBase + UartThrOff, value, 32'h0, 1'b0);
    end
    expect_access(1'b0, UartBase + UartLsrOff, 32'h0, UartLsrIdle, 1'b0);
    expect_access(1'b0, UartBase + 32'h4, 32'h0, 32'h0, 1'b0);
    assert (char_count == writes)
      else report_mismatch($sformatf("%0d character strobes for %0d writes",
                                     char_count, writes));

    // Enable clear, dispatches leave the counter stopped
    drive_burst(6);
    wait_for_idle();
    read_runtime(runtime);
    assert (runtime == 64'h0) else report_mismatch("runtime moved with enable clear");

    // Enabled bursts, each drain latches a new runtime
    expect_access(1'b1, RegCntEnOff, 32'h1, 32'h0, 1'b0);
    drive_burst(8);
    wait_for_idle();
    read_runtime(runtime);
    assert (runtime != 64'h0) else report_mismatch("runtime zero after enabled burst");
    prev_runtime = runtime;
    drive_burst(5);
    wait_for_idle();
    read_runtime(runtime);
    assert (runtime > prev_runtime) else report_mismatch("second burst left runtime stale");
    prev_runtime = runtime;

    // Clear the enable while a long burst is still running
    @(negedge clk_i);
    acc_valid           = 1'b1;
    acc_req.busy_cycles = 8'd200;
    drive_burst(3);
    assert (!acc_idle) else report_mismatch("accelerator idle before enable clear");
    expect_access(1'b1, RegCntEnOff, 32'h0, 32'h0, 1'b0);
    expect_access(1'b0, RegCntEnOff, 32'h0, 32'h0, 1'b0);
    wait_for_idle();
    read_runtime(runtime);
    assert (runtime > prev_runtime + 64'd200)
      else report_mismatch("counting stopped before the accelerator drained");

    // Further dispatches with the enable clear
    drive_burst(4);
    wait_for_idle();
    read_runtime(runtime);

    $display("TESTS PASSED");
    $finish;
  end

endmodule : tb_vec_runtime

// ==== vec_runtime.f ====
verilog/vec_runtime_pkg.sv
verilog/acc_busy_model.sv
verilog/runtime_counter.sv
verilog/mock_uart.sv
verilog/ctrl_regs.sv
verilog/vec_runtime_harness.sv
verif/tb_vec_runtime.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the vector runtime harness testbench with Verilator, run it and
# decide pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=vsim_vec_runtime
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
  -f vec_runtime.f --top-module tb_vec_runtime \
  -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG_FILE"; then
  echo "Simulation passed, log in $LOG_FILE"
  exit 0
else
  echo "Simulation failed, log in $LOG_FILE"
  exit 1
fi
